/* source/adc_pkg.sv */
//--------------------------------------------------
// Sample stream definitions
// Widths, saturation limit, filter output struct
//--------------------------------------------------
package adc_pkg;

	//--------------------------------------------------
	// Sample format
	//--------------------------------------------------
	// Unsigned sample as an ADC would deliver it
	localparam int SAMPLE_W = 14;
	// Saturation value, all ones
	localparam logic [SAMPLE_W-1:0] SAMPLE_MAX = '1;

	//--------------------------------------------------
	// Filter widths
	//--------------------------------------------------
	// Largest boxcar window exponent
	localparam int MAX_WIN_LOG2 = 6;
	// Room for 2^MAX_WIN_LOG2 full scale samples
	localparam int SUM_W = SAMPLE_W + MAX_WIN_LOG2;
	// One extra bit for the sign of a difference
	localparam int DIFF_W = SAMPLE_W + 1;

	// Both filter results, leaving the top level together
	typedef struct packed {
		logic [SUM_W-1:0] sum;
		logic signed [DIFF_W-1:0] diff;
	} filter_out_t;

endpackage

/* source/cfg_pkg.sv */
//--------------------------------------------------
// Configuration port definitions
// Register map, handshake states, pulse settings
//--------------------------------------------------
package cfg_pkg;

	// Register map of the configuration port
	typedef enum logic [1:0] {
		// Bit 0 enable, bit 1 overlay
		REG_CTRL   = 2'd0,
		// Pulse amplitude in sample units
		REG_AMPL   = 2'd1,
		// Trigger period in clocks
		REG_PERIOD = 2'd2
	} cfg_addr_e;

	// Four-phase handshake states of the register block
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		ACK_HIGH  = 2'd1,
		WAIT_DROP = 2'd2
	} hs_state_e;

	// Period counter width
	localparam int PERIOD_W = 16;

	// Settings that steer the pulse source
	typedef struct packed {
		logic enable;
		logic overlay;
		logic [adc_pkg::SAMPLE_W-1:0] ampl;
		logic [PERIOD_W-1:0] period;
	} pulse_cfg_t;

endpackage

/* source/cfg_regs.sv */
//--------------------------------------------------
// Pulse configuration register block
// Written through a four-phase req/ack port
//--------------------------------------------------
`timescale 1ns/1ps

module cfg_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	// Configuration port
	input  logic                 cfg_req,
	input  cfg_pkg::cfg_addr_e   cfg_addr,
	input  logic [15:0]          cfg_wdata,
	output logic                 cfg_ack,
	// Settings to the pulse source
	output cfg_pkg::pulse_cfg_t  cfg
);
	import cfg_pkg::*;
	import adc_pkg::*;

	hs_state_e state;
	// A request is taken when the port is idle
	logic take_req;

	//--------------------------------------------------
	// Handshake FSM
	//--------------------------------------------------
	// WAIT_DROP marks the cycle after ack fell
	// A fresh request there is served at once
	assign take_req = cfg_req && (state == IDLE || state == WAIT_DROP);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			cfg_ack <= 1'b0;
		end else begin
			case (state)
				IDLE, WAIT_DROP: begin
					if (cfg_req) begin
						state <= ACK_HIGH;
						cfg_ack <= 1'b1;
					end else begin
						state <= IDLE;
					end
				end
				ACK_HIGH: begin
					// Held here as long as the master keeps req high
					if (!cfg_req) begin
						state <= WAIT_DROP;
						cfg_ack <= 1'b0;
					end
				end
				default: begin
					state <= IDLE;
					cfg_ack <= 1'b0;
				end
			endcase
		end
	end

	//--------------------------------------------------
	// Register write
	//--------------------------------------------------
	// Same edge as the rising ack
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (take_req) begin
			case (cfg_addr)
				REG_CTRL: begin
					cfg.enable <= cfg_wdata[0];
					cfg.overlay <= cfg_wdata[1];
				end
				REG_AMPL:   cfg.ampl <= cfg_wdata[SAMPLE_W-1:0];
				REG_PERIOD: cfg.period <= cfg_wdata[PERIOD_W-1:0];
				// Unmapped address, handshake only
				default: ;
			endcase
		end
	end

	//--------------------------------------------------
	// Protocol checks
	//--------------------------------------------------
	// Ack answers a request seen on the previous edge
	ack_rise_on_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cfg_ack) |-> $past(cfg_req));
	// Ack only falls once the master let go of req
	ack_fall_on_drop: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cfg_ack) |-> !$past(cfg_req));

endmodule

/* source/pulse_gen.sv */
//--------------------------------------------------
// Periodic exponential pulse source
// Restart or pile-up at each trigger, shift decay
//--------------------------------------------------
`timescale 1ns/1ps

module pulse_gen #(
	parameter int DECAY_SHIFT = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  cfg_pkg::pulse_cfg_t           cfg,
	output logic [adc_pkg::SAMPLE_W-1:0]  sample
);
	import adc_pkg::*;
	import cfg_pkg::*;

	logic [PERIOD_W-1:0] period_cnt;
	logic [PERIOD_W-1:0] period_last;
	logic trigger;
	logic [SAMPLE_W-1:0] decayed;
	// One bit wider to catch the overflow
	logic [SAMPLE_W:0] piled;
	logic [SAMPLE_W-1:0] sample_next;

	//--------------------------------------------------
	// Trigger timing
	//--------------------------------------------------
	// Fires every period clocks, counter wraps on it
	assign period_last = cfg.period - PERIOD_W'(1);
	assign trigger = cfg.enable && (period_cnt == period_last);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			period_cnt <= '0;
		end else if (!cfg.enable || trigger) begin
			period_cnt <= '0;
		end else begin
			period_cnt <= period_cnt + PERIOD_W'(1);
		end
	end

	//--------------------------------------------------
	// Sample update
	//--------------------------------------------------
	always_comb begin
		// y - y/2^DECAY_SHIFT
		decayed = sample - (sample >> DECAY_SHIFT);
		piled = {1'b0, decayed} + {1'b0, cfg.ampl};
		if (!cfg.enable)
			sample_next = '0;
		else if (trigger && cfg.overlay)
			// Pile on the tail, clip at full scale
			sample_next = piled[SAMPLE_W] ? SAMPLE_MAX : piled[SAMPLE_W-1:0];
		else if (trigger)
			sample_next = cfg.ampl;
		else
			sample_next = decayed;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			sample <= '0;
		else
			sample <= sample_next;
	end

	//--------------------------------------------------
	// Checks against the register settings
	//--------------------------------------------------
	// Disabled source is silent from the next edge
	off_means_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(cfg.enable) |-> sample == '0);
	// Without overlay a pulse never grows beyond ampl
	no_overlay_bound: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(cfg.overlay) |->
			(sample <= $past(sample)) || (sample <= $past(cfg.ampl)));

endmodule

/* source/moving_sum_filter.sv */
//--------------------------------------------------
// Boxcar filter
// Running sum over 2^WIN_LOG2 samples
//--------------------------------------------------
`timescale 1ns/1ps

module moving_sum_filter #(
	parameter int WIN_LOG2 = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [adc_pkg::SAMPLE_W-1:0]  in_sample,
	output logic [adc_pkg::SUM_W-1:0]     sum
);
	import adc_pkg::*;

	localparam int WIN = 1 << WIN_LOG2;
	// Largest sum a full window of full scale can give
	localparam logic [SUM_W-1:0] SUM_LIMIT = SUM_W'(SAMPLE_MAX) * SUM_W'(WIN);

	//--------------------------------------------------
	// Window history
	//--------------------------------------------------
	// Entry 0 newest, entry WIN-1 about to leave
	logic [SAMPLE_W-1:0] hist [WIN];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < WIN; i++)
				hist[i] <= '0;
		end else begin
			hist[0] <= in_sample;
			for (int i = 1; i < WIN; i++)
				hist[i] <= hist[i-1];
		end
	end

	//--------------------------------------------------
	// Accumulator
	//--------------------------------------------------
	// Add the arriving sample, drop the oldest one
	always_ff @(posedge clk) begin
		if (!rst_n)
			sum <= '0;
		else
			sum <= sum + SUM_W'(in_sample) - SUM_W'(hist[WIN-1]);
	end

	// Accumulator stays consistent with the history
	sum_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		sum <= SUM_LIMIT);

endmodule

/* source/delay_diff_filter.sv */
//--------------------------------------------------
// Delay-difference shaper
// x[n] - x[n-DIFF_DELAY], registered, signed
//--------------------------------------------------
`timescale 1ns/1ps

module delay_diff_filter #(
	parameter int DIFF_DELAY = 5
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [adc_pkg::SAMPLE_W-1:0]        in_sample,
	output logic signed [adc_pkg::DIFF_W-1:0]   diff
);
	import adc_pkg::*;

	//--------------------------------------------------
	// Delay line
	//--------------------------------------------------
	// Entry k holds the sample from k+1 clocks back
	logic [SAMPLE_W-1:0] dly [DIFF_DELAY];
	logic signed [DIFF_W-1:0] cur_s;
	logic signed [DIFF_W-1:0] old_s;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DIFF_DELAY; i++)
				dly[i] <= '0;
		end else begin
			dly[0] <= in_sample;
			for (int i = 1; i < DIFF_DELAY; i++)
				dly[i] <= dly[i-1];
		end
	end

	//--------------------------------------------------
	// Difference
	//--------------------------------------------------
	// Zero extend before the signed subtract
	assign cur_s = $signed({1'b0, in_sample});
	assign old_s = $signed({1'b0, dly[DIFF_DELAY-1]});

	// Slow tail cancels, leaving a short pulse
	always_ff @(posedge clk) begin
		if (!rst_n)
			diff <= '0;
		else
			diff <= cur_s - old_s;
	end

endmodule

/* source/filter_bench_top.sv */
//--------------------------------------------------
// Filter bench top level
// Registers, pulse source, boxcar and delay-diff
//--------------------------------------------------
`timescale 1ns/1ps

module filter_bench_top #(
	parameter int DECAY_SHIFT = 3,
	parameter int WIN_LOG2 = 3,
	parameter int DIFF_DELAY = 5
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// Configuration port
	input  logic                          cfg_req,
	input  cfg_pkg::cfg_addr_e            cfg_addr,
	input  logic [15:0]                   cfg_wdata,
	output logic                          cfg_ack,
	// Raw and filtered streams
	output logic [adc_pkg::SAMPLE_W-1:0]  sample,
	output adc_pkg::filter_out_t          fout
);
	import cfg_pkg::*;

	// Settings from the register block
	pulse_cfg_t cfg;

	//--------------------------------------------------
	// Configuration
	//--------------------------------------------------
	cfg_regs u_cfg_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_req   (cfg_req),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_ack   (cfg_ack),
		.cfg       (cfg)
	);

	//--------------------------------------------------
	// Source and filters
	//--------------------------------------------------
	pulse_gen #(.DECAY_SHIFT(DECAY_SHIFT)) u_pulse_gen (
		.clk    (clk),
		.rst_n  (rst_n),
		.cfg    (cfg),
		.sample (sample)
	);

	// Both filters see the same raw stream
	moving_sum_filter #(.WIN_LOG2(WIN_LOG2)) u_moving_sum (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_sample (sample),
		.sum       (fout.sum)
	);

	delay_diff_filter #(.DIFF_DELAY(DIFF_DELAY)) u_delay_diff (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_sample (sample),
		.diff      (fout.diff)
	);

endmodule

/* verif/tb_checker.sv */
//--------------------------------------------------
// Testbench checker
// Reference model of pulse source and filters
// Per-cycle compare of sample, fout, handshake
//--------------------------------------------------
`timescale 1ns/1ps

module tb_checker #(
	parameter int DECAY_SHIFT = 3,
	parameter int WIN_LOG2 = 3,
	parameter int DIFF_DELAY = 5
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cfg_req,
	input  cfg_pkg::cfg_addr_e            cfg_addr,
	input  logic [15:0]                   cfg_wdata,
	input  logic                          cfg_ack,
	input  logic [adc_pkg::SAMPLE_W-1:0]  sample,
	input  adc_pkg::filter_out_t          fout,
	output int                            err_cnt,
	output int                            sat_cnt
);
	import adc_pkg::*;
	import cfg_pkg::*;

	localparam int HIST_N = 1 << MAX_WIN_LOG2;
	typedef logic [SAMPLE_W-1:0] hist_t [HIST_N];

	// Observed samples, entry 0 the latest
	hist_t hist;
	// Registers as last written over the port
	pulse_cfg_t m_cfg;
	// Trigger phase, counted from enable
	logic [PERIOD_W-1:0] m_cnt;
	logic prev_req;
	logic prev_ack;
	int errs = 0;
	int sats = 0;

	assign err_cnt = errs;
	assign sat_cnt = sats;

	//--------------------------------------------------
	// Reference functions
	//--------------------------------------------------
	// Decay by y/2^DECAY_SHIFT, restart or pile up on a trigger
	function automatic logic [SAMPLE_W-1:0] next_sample(
		input logic [SAMPLE_W-1:0] y,
		input logic trig,
		input pulse_cfg_t c
	);
		logic [SAMPLE_W-1:0] dec;
		logic [SAMPLE_W:0] tot;
		dec = y - (y >> DECAY_SHIFT);
		tot = {1'b0, dec} + {1'b0, c.ampl};
		if (!c.enable)
			return '0;
		if (!trig)
			return dec;
		if (!c.overlay)
			return c.ampl;
		return (tot > {1'b0, SAMPLE_MAX}) ? SAMPLE_MAX : tot[SAMPLE_W-1:0];
	endfunction

	function automatic logic [SUM_W-1:0] window_sum(input hist_t h, input int n);
		logic [SUM_W-1:0] s;
		s = '0;
		for (int i = 0; i < n; i++)
			s = s + SUM_W'(h[i]);
		return s;
	endfunction

	function automatic logic signed [DIFF_W-1:0] delayed_diff(input hist_t h, input int d);
		return $signed({1'b0, h[0]}) - $signed({1'b0, h[d]});
	endfunction

	//--------------------------------------------------
	// Compare at the falling edge, mid cycle
	//--------------------------------------------------
	always @(negedge clk) begin : compare
		logic trig;
		logic [SAMPLE_W-1:0] exp_sample;
		logic [SUM_W-1:0] exp_sum;
		logic signed [DIFF_W-1:0] exp_diff;
		if (!rst_n) begin
			m_cfg = '0;
			m_cnt = '0;
			prev_req = 1'b0;
			prev_ack = 1'b0;
			for (int i = 0; i < HIST_N; i++)
				hist[i] = '0;
		end else begin
			// Trigger on the last count of each period
			trig = m_cfg.enable && (m_cnt == m_cfg.period - PERIOD_W'(1));
			exp_sample = next_sample(hist[0], trig, m_cfg);
			exp_sum = window_sum(hist, 1 << WIN_LOG2);
			exp_diff = delayed_diff(hist, DIFF_DELAY);
			if (sample != exp_sample) begin
				errs++;
				$display("Error: sample expected %h got %h at %0t",
					exp_sample, sample, $time);
			end
			if (fout.sum != exp_sum) begin
				errs++;
				$display("Error: fout.sum expected %h got %h at %0t",
					exp_sum, fout.sum, $time);
			end
			if (fout.diff != exp_diff) begin
				errs++;
				$display("Error: fout.diff expected %h got %h at %0t",
					exp_diff, fout.diff, $time);
			end
			if (sample == SAMPLE_MAX)
				sats++;
			// Four-phase ordering
			if (cfg_ack && !prev_ack && !prev_req) begin
				errs++;
				$display("Handshake error: cfg_ack rose with no request at %0t", $time);
			end
			if (!cfg_ack && prev_ack && prev_req) begin
				errs++;
				$display("Handshake error: cfg_ack fell while cfg_req was high at %0t", $time);
			end
			if (cfg_req && !prev_req && cfg_ack) begin
				errs++;
				$display("Handshake error: new request before cfg_ack dropped at %0t", $time);
			end
			// Model state for the next cycle
			m_cnt = (!m_cfg.enable || trig) ? '0 : m_cnt + PERIOD_W'(1);
			// Write lands on the edge that raised ack
			if (cfg_ack && !prev_ack) begin
				case (cfg_addr)
					REG_CTRL: begin
						m_cfg.enable = cfg_wdata[0];
						m_cfg.overlay = cfg_wdata[1];
					end
					REG_AMPL:   m_cfg.ampl = cfg_wdata[SAMPLE_W-1:0];
					REG_PERIOD: m_cfg.period = cfg_wdata;
					default: ;
				endcase
			end
			for (int i = HIST_N - 1; i > 0; i--)
				hist[i] = hist[i-1];
			hist[0] = sample;
			prev_req = cfg_req;
			prev_ack = cfg_ack;
		end
	end

endmodule

/* verif/tb_top.sv */
//--------------------------------------------------
// Filter bench testbench top
// Clock, reset, four-phase register writes
// Test sequence, watchdog, closing line
//--------------------------------------------------
`timescale 1ns/1ps

module tb_top;
	import adc_pkg::*;
	import cfg_pkg::*;

	localparam int DECAY_SHIFT = 3;
	localparam int WIN_LOG2 = 3;
	localparam int DIFF_DELAY = 5;
	// Pulses per test window
	localparam int PULSES = 6;
	localparam int OV_PULSES = 20;
	// Clocks allowed for each handshake phase
	localparam int HS_LIMIT = 16;

	logic clk;
	logic rst_n;
	logic cfg_req;
	cfg_addr_e cfg_addr;
	logic [15:0] cfg_wdata;
	logic cfg_ack;
	logic [SAMPLE_W-1:0] sample;
	filter_out_t fout;
	int chk_errs;
	int sat_cnt;
	int tb_errs;
	int seed;
	int limit_cycles;
	logic [15:0] ampl_a;
	logic [15:0] ampl_b;
	logic [15:0] ampl_ov;
	logic [15:0] period_a;
	logic [15:0] period_ov;

	filter_bench_top #(
		.DECAY_SHIFT(DECAY_SHIFT),
		.WIN_LOG2(WIN_LOG2),
		.DIFF_DELAY(DIFF_DELAY)
	) dut0 (.*);

	// Watches the DUT ports, keeps its own model
	tb_checker #(
		.DECAY_SHIFT(DECAY_SHIFT),
		.WIN_LOG2(WIN_LOG2),
		.DIFF_DELAY(DIFF_DELAY)
	) chk0 (.*, .err_cnt(chk_errs));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//--------------------------------------------------
	// Four-phase write, driven 2 ns after the edge
	//--------------------------------------------------
	// Hold keeps req up for extra clocks once ack is seen
	task automatic reg_write(input cfg_addr_e addr, input logic [15:0] data,
		input int hold = 0);
		int n;
		@(posedge clk);
		#2;
		cfg_addr = addr;
		cfg_wdata = data;
		cfg_req = 1'b1;
		n = 0;
		while (!cfg_ack && n < HS_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!cfg_ack) begin
			tb_errs++;
			$display("Handshake timeout: no ack for write to %s", addr.name());
		end
		// Slow master, ack must stay up meanwhile
		repeat (hold) begin
			@(posedge clk);
			#2;
		end
		// Addr and data stay put until the next write
		cfg_req = 1'b0;
		n = 0;
		while (cfg_ack && n < HS_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (cfg_ack) begin
			tb_errs++;
			$display("Handshake timeout: ack stuck high after write to %s", addr.name());
		end
	endtask

	//--------------------------------------------------
	// Test sequence
	//--------------------------------------------------
	initial begin
		seed = 32'h77b9;
		tb_errs = 0;
		cfg_req = 1'b0;
		cfg_addr = REG_CTRL;
		cfg_wdata = '0;
		rst_n = 1'b0;
		// Restart pulses stay below half scale, pile-up clips
		period_a = 16'(12 + {$random(seed)} % 32);
		ampl_a = 16'(1000 + {$random(seed)} % 7000);
		ampl_b = 16'(1000 + {$random(seed)} % 7000);
		period_ov = 16'(2 + {$random(seed)} % 2);
		ampl_ov = 16'(6000 + {$random(seed)} % 2000);
		// Test windows plus room for writes, idle and drain
		limit_cycles = 300 + 2 * PULSES * int'(period_a) + OV_PULSES * int'(period_ov);
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// Source silent until enabled
		repeat (10) @(posedge clk);

		// Restart mode, amplitude changed halfway
		reg_write(REG_PERIOD, period_a);
		reg_write(REG_AMPL, ampl_a);
		reg_write(REG_CTRL, 16'h0001);
		repeat (PULSES * int'(period_a)) @(posedge clk);
		// Req held high, block waits in ACK_HIGH
		reg_write(REG_AMPL, ampl_b, 4);
		repeat (PULSES * int'(period_a)) @(posedge clk);

		// Pile-up mode, period changed while off
		reg_write(REG_CTRL, 16'h0000);
		reg_write(REG_PERIOD, period_ov);
		reg_write(REG_AMPL, ampl_ov);
		reg_write(REG_CTRL, 16'h0003);
		repeat (OV_PULSES * int'(period_ov)) @(posedge clk);
		if (sat_cnt == 0) begin
			tb_errs++;
			$display("Pile-up run never reached full scale");
		end

		// Off, both filters drain
		reg_write(REG_CTRL, 16'h0000);
		repeat (10) @(posedge clk);
		#2;
		if (sample != '0 || fout != '0) begin
			tb_errs++;
			$display("Error: fout expected 0 got %h, sample %h", fout, sample);
		end

		$display("Errors: checker %0d, testbench %0d", chk_errs, tb_errs);
		if (chk_errs + tb_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog, limit known once the randoms are drawn
	initial begin
		#1;
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: run did not finish within %0d clocks", limit_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* list.f */
source/adc_pkg.sv
source/cfg_pkg.sv
source/cfg_regs.sv
source/pulse_gen.sv
source/moving_sum_filter.sv
source/delay_diff_filter.sv
source/filter_bench_top.sv
verif/tb_checker.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the filter bench testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_top --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1
